// ==== logic/cachePkg.sv ====
// shared types and address layout for the two-way cache.
package cachePkg;

    // processor byte address.
    localparam int addrWidth = 32;

    // byte offset bits within one 32-bit word.
    localparam int offsetWidth = 2;

    // controller states.
    // Sweep clears the valid bits of one set per cycle after reset.
    // Lookup spends one cycle reading the RAMs and one comparing tags.
    // Refill and WriteMem each issue one memory strobe and wait for the ack.
    // Install writes the refilled line into the victim way.
    typedef enum logic [2:0] {
        Sweep,
        Idle,
        Lookup,
        Refill,
        WriteMem,
        Respond,
        Install
    } ctrlState;

    // request kind latched on cpuReq.
    typedef enum logic {
        Read,
        Write
    } accessKind;

endpackage

// ==== logic/wayPortIf.sv ====
interface wayPortIf #(
    parameter int indexWidth = 7,
    parameter int dataWidth  = 32
) ();

    localparam int tagWidth = cachePkg::addrWidth - cachePkg::offsetWidth - indexWidth;

    logic [indexWidth-1:0] readIndex;
    logic [indexWidth-1:0] writeIndex;
    logic                  writeEnable;
    logic [tagWidth-1:0]   writeTag;
    logic [dataWidth-1:0]  writeData;
    logic                  writeValid;
    logic [tagWidth-1:0]   lookupTag;
    logic                  hit;
    logic [dataWidth-1:0]  readData;

    modport controller (
        output readIndex, writeIndex, writeEnable, writeTag, writeData, writeValid, lookupTag,
        input  hit, readData
    );

    modport way (
        input  readIndex, writeIndex, writeEnable, writeTag, writeData, writeValid, lookupTag,
        output hit, readData
    );

endinterface

// ==== logic/dualPortRam.sv ====
module dualPortRam #(
    parameter int width = 32,
    parameter int depth = 128
) (
    input  logic                     clk,
    input  logic                     writeEnable,
    input  logic [$clog2(depth)-1:0] writeAddr,
    input  logic [width-1:0]         writeData,
    input  logic [$clog2(depth)-1:0] readAddr,
    output logic [width-1:0]         readData
);

    logic [width-1:0] mem [depth];

    // write port.
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeAddr] <= writeData;
        end
    end

    // read port, registered like a block RAM output.
    // a read of the address being written returns the old word.
    always_ff @(posedge clk) begin
        readData <= mem[readAddr];
    end

endmodule

// ==== logic/cacheWay.sv ====
module cacheWay #(
    parameter int indexWidth = 7,
    parameter int dataWidth  = 32
) (
    input logic   clk,
    wayPortIf.way wayPort
);

    localparam int tagWidth = cachePkg::addrWidth - cachePkg::offsetWidth - indexWidth;
    localparam int sets     = 2 ** indexWidth;

    logic [tagWidth-1:0] storedTag;
    logic                storedValid;

    dualPortRam #(.width(tagWidth), .depth(sets)) tagRam (
        .clk        (clk),
        .writeEnable(wayPort.writeEnable),
        .writeAddr  (wayPort.writeIndex),
        .writeData  (wayPort.writeTag),
        .readAddr   (wayPort.readIndex),
        .readData   (storedTag)
    );

    dualPortRam #(.width(dataWidth), .depth(sets)) dataRam (
        .clk        (clk),
        .writeEnable(wayPort.writeEnable),
        .writeAddr  (wayPort.writeIndex),
        .writeData  (wayPort.writeData),
        .readAddr   (wayPort.readIndex),
        .readData   (wayPort.readData)
    );

    dualPortRam #(.width(1), .depth(sets)) validRam (
        .clk        (clk),
        .writeEnable(wayPort.writeEnable),
        .writeAddr  (wayPort.writeIndex),
        .writeData  (wayPort.writeValid),
        .readAddr   (wayPort.readIndex),
        .readData   (storedValid)
    );

    // tag match only counts on a valid line.
    assign wayPort.hit = storedValid && (storedTag == wayPort.lookupTag);

endmodule

// ==== logic/lruTable.sv ====
module lruTable #(
    parameter int indexWidth = 7
) (
    input  logic                  clk,
    input  logic [indexWidth-1:0] readIndex,
    input  logic                  updateEnable,
    input  logic [indexWidth-1:0] updateIndex,
    input  logic                  updateWay,
    output logic                  victimWay
);

    logic notUsedWay;

    // the stored bit names the way to replace next.
    assign notUsedWay = !updateWay;

    dualPortRam #(.width(1), .depth(2 ** indexWidth)) lruRam (
        .clk        (clk),
        .writeEnable(updateEnable),
        .writeAddr  (updateIndex),
        .writeData  (notUsedWay),
        .readAddr   (readIndex),
        .readData   (victimWay)
    );

endmodule

// ==== logic/cacheController.sv ====
module cacheController #(
    parameter int indexWidth = 7,
    parameter int dataWidth  = 32
) (
    input  logic                                                  clk,
    input  logic                                                  rstN,
    input  logic                                                  cpuReq,
    input  logic                                                  cpuWrite,
    input  logic [cachePkg::addrWidth-1:0]                        cpuAddr,
    input  logic [dataWidth-1:0]                                  cpuWriteData,
    output logic [dataWidth-1:0]                                  cpuReadData,
    output logic                                                  cpuDone,
    output logic                                                  busy,
    output logic                                                  memRead,
    output logic                                                  memWrite,
    output logic [cachePkg::addrWidth-cachePkg::offsetWidth-1:0]  memAddr,
    output logic [dataWidth-1:0]                                  memWriteData,
    input  logic [dataWidth-1:0]                                  memReadData,
    input  logic                                                  memAck,
    wayPortIf.controller                                          way0,
    wayPortIf.controller                                          way1,
    output logic                                                  lruUpdateEnable,
    output logic [indexWidth-1:0]                                 lruUpdateIndex,
    output logic                                                  lruUpdateWay,
    output logic [indexWidth-1:0]                                 lruReadIndex,
    input  logic                                                  victimWay
);

    localparam int tagWidth = cachePkg::addrWidth - cachePkg::offsetWidth - indexWidth;

    cachePkg::ctrlState  state;
    cachePkg::accessKind reqKind;

    logic                  lookupReady;
    logic                  memIssued;
    logic [indexWidth-1:0] sweepCount;
    logic                  sweepWe;
    logic [indexWidth-1:0] sweepIdx;

    logic [tagWidth-1:0]   reqTag;
    logic [indexWidth-1:0] reqIndex;
    logic [dataWidth-1:0]  reqWriteData;
    logic [dataWidth-1:0]  respData;
    logic                  fillWay;

    logic                  lookupDone;
    logic                  anyHit;
    logic                  ackSeen;
    logic                  hitWrite;
    logic [1:0]            wayWrite;
    logic [indexWidth-1:0] writeIdx;
    logic [dataWidth-1:0]  lineData;

    assign lookupDone = (state == cachePkg::Lookup) && lookupReady;
    assign anyHit     = way0.hit || way1.hit;
    assign ackSeen    = memIssued && memAck;
    assign hitWrite   = lookupDone && (reqKind == cachePkg::Write);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= cachePkg::Sweep;
            lookupReady <= 1'b0;
            memIssued   <= 1'b0;
            sweepCount  <= '0;
            sweepWe     <= 1'b0;
        end else begin
            // sweep writes trail the counter by one cycle.
            sweepWe <= (state == cachePkg::Sweep);
            case (state)
                cachePkg::Sweep: begin
                    sweepCount <= sweepCount + 1'b1;
                    if (&sweepCount) begin
                        state <= cachePkg::Idle;
                    end
                end
                cachePkg::Idle: begin
                    if (cpuReq) begin
                        state <= cachePkg::Lookup;
                    end
                end
                cachePkg::Lookup: begin
                    // first cycle reads the RAMs, second compares.
                    lookupReady <= !lookupReady;
                    if (lookupReady) begin
                        if (reqKind == cachePkg::Write) begin
                            state <= cachePkg::WriteMem;
                        end else if (anyHit) begin
                            state <= cachePkg::Respond;
                        end else begin
                            state <= cachePkg::Refill;
                        end
                    end
                end
                cachePkg::Refill: begin
                    memIssued <= 1'b1;
                    if (ackSeen) begin
                        memIssued <= 1'b0;
                        state     <= cachePkg::Install;
                    end
                end
                cachePkg::WriteMem: begin
                    memIssued <= 1'b1;
                    if (ackSeen) begin
                        memIssued <= 1'b0;
                        state     <= cachePkg::Respond;
                    end
                end
                cachePkg::Respond,
                cachePkg::Install: begin
                    state <= cachePkg::Idle;
                end
                default: begin
                    state <= cachePkg::Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        sweepIdx <= sweepCount;
        if ((state == cachePkg::Idle) && cpuReq) begin
            reqKind      <= cpuWrite ? cachePkg::Write : cachePkg::Read;
            reqTag       <= cpuAddr[cachePkg::addrWidth-1 -: tagWidth];
            reqIndex     <= cpuAddr[cachePkg::offsetWidth +: indexWidth];
            reqWriteData <= cpuWriteData;
        end
        if (lookupDone) begin
            respData <= way1.hit ? way1.readData : way0.readData;
            // an unwritten LRU bit falls back to way 0.
            if (victimWay) begin
                fillWay <= 1'b1;
            end else begin
                fillWay <= 1'b0;
            end
        end
        if ((state == cachePkg::Refill) && ackSeen) begin
            respData <= memReadData;
        end
    end

    assign busy         = (state != cachePkg::Idle);
    assign cpuDone      = (state == cachePkg::Respond) || (state == cachePkg::Install);
    assign cpuReadData  = respData;

    // one strobe per access, on the first cycle of the wait.
    assign memRead      = (state == cachePkg::Refill) && !memIssued;
    assign memWrite     = (state == cachePkg::WriteMem) && !memIssued;
    assign memAddr      = {reqTag, reqIndex};
    assign memWriteData = reqWriteData;

    // sweep clears both ways, a write hit updates its way, install fills the victim.
    assign wayWrite[0] = sweepWe || (hitWrite && way0.hit)
                         || ((state == cachePkg::Install) && !fillWay);
    assign wayWrite[1] = sweepWe || (hitWrite && way1.hit)
                         || ((state == cachePkg::Install) && fillWay);
    assign writeIdx    = sweepWe ? sweepIdx : reqIndex;
    assign lineData    = (state == cachePkg::Install) ? respData : reqWriteData;

    assign way0.readIndex   = reqIndex;
    assign way0.writeIndex  = writeIdx;
    assign way0.writeEnable = wayWrite[0];
    assign way0.writeTag    = reqTag;
    assign way0.writeData   = lineData;
    assign way0.writeValid  = !sweepWe;
    assign way0.lookupTag   = reqTag;

    assign way1.readIndex   = reqIndex;
    assign way1.writeIndex  = writeIdx;
    assign way1.writeEnable = wayWrite[1];
    assign way1.writeTag    = reqTag;
    assign way1.writeData   = lineData;
    assign way1.writeValid  = !sweepWe;
    assign way1.lookupTag   = reqTag;

    // hits and refills both mark the used way.
    assign lruReadIndex    = reqIndex;
    assign lruUpdateEnable = (lookupDone && anyHit) || (state == cachePkg::Install);
    assign lruUpdateIndex  = reqIndex;
    assign lruUpdateWay    = (state == cachePkg::Install) ? fillWay : way1.hit;

endmodule

// ==== logic/cacheTop.sv ====
module cacheTop #(
    parameter int indexWidth = 7,
    parameter int dataWidth  = 32
) (
    input  logic                                                 clk,
    input  logic                                                 rstN,
    input  logic                                                 cpuReq,
    input  logic                                                 cpuWrite,
    input  logic [cachePkg::addrWidth-1:0]                       cpuAddr,
    input  logic [dataWidth-1:0]                                 cpuWriteData,
    output logic [dataWidth-1:0]                                 cpuReadData,
    output logic                                                 cpuDone,
    output logic                                                 busy,
    output logic                                                 memRead,
    output logic                                                 memWrite,
    output logic [cachePkg::addrWidth-cachePkg::offsetWidth-1:0] memAddr,
    output logic [dataWidth-1:0]                                 memWriteData,
    input  logic [dataWidth-1:0]                                 memReadData,
    input  logic                                                 memAck
);

    logic [indexWidth-1:0] lruReadIndex;
    logic                  lruUpdateEnable;
    logic [indexWidth-1:0] lruUpdateIndex;
    logic                  lruUpdateWay;
    logic                  victimWay;

    wayPortIf #(.indexWidth(indexWidth), .dataWidth(dataWidth)) way0If ();
    wayPortIf #(.indexWidth(indexWidth), .dataWidth(dataWidth)) way1If ();

    cacheController #(.indexWidth(indexWidth), .dataWidth(dataWidth)) controller (
        .clk            (clk),
        .rstN           (rstN),
        .cpuReq         (cpuReq),
        .cpuWrite       (cpuWrite),
        .cpuAddr        (cpuAddr),
        .cpuWriteData   (cpuWriteData),
        .cpuReadData    (cpuReadData),
        .cpuDone        (cpuDone),
        .busy           (busy),
        .memRead        (memRead),
        .memWrite       (memWrite),
        .memAddr        (memAddr),
        .memWriteData   (memWriteData),
        .memReadData    (memReadData),
        .memAck         (memAck),
        .way0           (way0If.controller),
        .way1           (way1If.controller),
        .lruUpdateEnable(lruUpdateEnable),
        .lruUpdateIndex (lruUpdateIndex),
        .lruUpdateWay   (lruUpdateWay),
        .lruReadIndex   (lruReadIndex),
        .victimWay      (victimWay)
    );

    cacheWay #(.indexWidth(indexWidth), .dataWidth(dataWidth)) way0 (
        .clk    (clk),
        .wayPort(way0If.way)
    );

    cacheWay #(.indexWidth(indexWidth), .dataWidth(dataWidth)) way1 (
        .clk    (clk),
        .wayPort(way1If.way)
    );

    lruTable #(.indexWidth(indexWidth)) lru (
        .clk         (clk),
        .readIndex   (lruReadIndex),
        .updateEnable(lruUpdateEnable),
        .updateIndex (lruUpdateIndex),
        .updateWay   (lruUpdateWay),
        .victimWay   (victimWay)
    );

endmodule

// ==== testbench/cacheTb.sv ====
module cacheTb;

    localparam int indexWidth    = 7;
    localparam int tagWidth      = 32 - 2 - indexWidth;
    localparam int sets          = 2 ** indexWidth;
    localparam int accessCount   = 20;
    localparam int worstAccess   = 16;
    localparam int timeoutCycles = 10 + sets + accessCount * worstAccess + 100;

    logic        clk = 1'b0;
    logic        rstN;
    logic        cpuReq;
    logic        cpuWrite;
    logic [31:0] cpuAddr;
    logic [31:0] cpuWriteData;
    logic [31:0] cpuReadData;
    logic        cpuDone;
    logic        busy;
    logic        memRead;
    logic        memWrite;
    logic [29:0] memAddr;
    logic [31:0] memWriteData;
    logic [31:0] memReadData;
    logic        memAck;

    // expectations for the access in flight.
    string       testName = "reset sweep";
    bit          pending = 1'b0;
    bit          expHit = 1'b0;
    bit          expMiss = 1'b0;
    bit          expWrite = 1'b0;
    logic [29:0] expAddr = '0;
    logic [31:0] expWData = '0;
    logic [31:0] expData = '0;
    int          readsAtStart = 0;
    int          writesAtStart = 0;

    int totalReads = 0;
    int totalWrites = 0;
    int reqAge = 0;
    int ackAge = 0;
    int sinceReset = 0;

    // shadow of the cache contents and the memory.
    logic [tagWidth-1:0] shTag [sets][2];
    bit                  shValid [sets][2];
    bit                  shVictim [sets];
    logic [29:0]         wordAddrs [$];
    logic [31:0]         wordData [$];

    integer      seed = 10;
    int          ackDelay;
    logic [31:0] respWord;

    cacheTop #(.indexWidth(indexWidth), .dataWidth(32)) dut_i (
        .clk(clk), .rstN(rstN),
        .cpuReq(cpuReq), .cpuWrite(cpuWrite), .cpuAddr(cpuAddr), .cpuWriteData(cpuWriteData),
        .cpuReadData(cpuReadData), .cpuDone(cpuDone), .busy(busy),
        .memRead(memRead), .memWrite(memWrite), .memAddr(memAddr),
        .memWriteData(memWriteData), .memReadData(memReadData), .memAck(memAck)
    );

    always #20 clk = ~clk;

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            sinceReset <= 0;
        end else begin
            sinceReset <= sinceReset + 1;
        end
    end

    always @(posedge clk) begin
        totalReads  <= totalReads + int'(memRead);
        totalWrites <= totalWrites + int'(memWrite);
        reqAge      <= (cpuReq && !busy) ? 0 : reqAge + 1;
        ackAge      <= memAck ? 1 : ackAge + 1;
    end

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        abortRun();
    endtask

    // sampled mid-cycle, where inputs and outputs are settled.
    sweepBusy: assert property (@(negedge clk)
        (sinceReset < sets) |-> (busy && !memRead && !memWrite && !cpuDone))
        else reportMismatch(testName, 32'h8, {busy, memRead, memWrite, cpuDone});
    sweepEnd: assert property (@(negedge clk) (sinceReset == sets) |-> !busy)
        else reportMismatch(testName, 32'h0, busy);
    strayDone: assert property (@(negedge clk) cpuDone |-> pending)
        else reportMismatch(testName, 32'h0, cpuDone);
    strayRead: assert property (@(negedge clk) memRead |-> (pending && expMiss))
        else reportMismatch(testName, 32'h0, memRead);
    strayWrite: assert property (@(negedge clk) memWrite |-> (pending && expWrite))
        else reportMismatch(testName, 32'h0, memWrite);
    strobeAddr: assert property (@(negedge clk) (memRead || memWrite) |-> (memAddr == expAddr))
        else reportMismatch(testName, expAddr, memAddr);
    strobeData: assert property (@(negedge clk) memWrite |-> (memWriteData == expWData))
        else reportMismatch(testName, expWData, memWriteData);
    readValue: assert property (@(negedge clk) (cpuDone && !expWrite) |-> (cpuReadData == expData))
        else reportMismatch(testName, expData, cpuReadData);
    hitLatency: assert property (@(negedge clk) (cpuDone && expHit && !expWrite) |-> (reqAge == 2))
        else reportMismatch(testName, 32'd2, reqAge);
    ackLatency: assert property (@(negedge clk)
        (cpuDone && !(expHit && !expWrite)) |-> (ackAge == 1))
        else reportMismatch(testName, 32'd1, ackAge);
    readCount: assert property (@(negedge clk)
        cpuDone |-> ((totalReads - readsAtStart) == int'(expMiss)))
        else reportMismatch(testName, int'(expMiss), totalReads - readsAtStart);
    writeCount: assert property (@(negedge clk)
        cpuDone |-> ((totalWrites - writesAtStart) == int'(expWrite)))
        else reportMismatch(testName, int'(expWrite), totalWrites - writesAtStart);

    function automatic logic [31:0] memWord(input logic [29:0] a);
        logic [31:0] word;
        word = {a[13:0], a[29:12]} ^ 32'h3C5A_96E1;
        foreach (wordAddrs[i]) begin
            if (wordAddrs[i] == a) begin
                word = wordData[i];
            end
        end
        return word;
    endfunction

    function automatic logic [31:0] makeAddr(input logic [tagWidth-1:0] tag,
                                             input logic [indexWidth-1:0] idx);
        return {tag, idx, 2'b00};
    endfunction

    // memory with an ack 1 to 6 cycles after each strobe.
    initial begin
        memAck = 1'b0;
        memReadData = '0;
        forever begin
            @(negedge clk);
            if (memRead || memWrite) begin
                ackDelay = 1 + ($unsigned($random(seed)) % 6);
                if (memWrite) begin
                    wordAddrs.push_back(memAddr);
                    wordData.push_back(memWriteData);
                end
                respWord = memWord(memAddr);
                repeat (ackDelay) @(posedge clk);
                #2;
                memAck = 1'b1;
                memReadData = respWord;
                @(posedge clk);
                #2;
                memAck = 1'b0;
            end
        end
    end

    task automatic predict(input bit write, input logic [31:0] addr, input logic [31:0] data);
        logic [tagWidth-1:0]   tag;
        logic [indexWidth-1:0] idx;
        int                    hitWay;
        int                    way;
        bit                    fill;
        tag    = addr[31 -: tagWidth];
        idx    = addr[2 +: indexWidth];
        hitWay = -1;
        for (way = 0; way < 2; way++) begin
            if (shValid[idx][way] && (shTag[idx][way] == tag)) begin
                hitWay = way;
            end
        end
        expHit   = (hitWay >= 0);
        expWrite = write;
        expMiss  = !write && (hitWay < 0);
        expAddr  = addr[31:2];
        expWData = data;
        expData  = write ? data : memWord(addr[31:2]);
        // the LRU bit points away from the way just used.
        if (hitWay >= 0) begin
            shVictim[idx] = (hitWay == 0);
        end else if (!write) begin
            fill = shVictim[idx];
            shValid[idx][fill] = 1'b1;
            shTag[idx][fill] = tag;
            shVictim[idx] = !fill;
        end
    endtask

    task automatic startAccess(input string name, input bit write, input logic [31:0] addr,
                               input logic [31:0] data);
        @(negedge clk);
        while (busy) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        testName = name;
        predict(write, addr, data);
        readsAtStart = totalReads;
        writesAtStart = totalWrites;
        pending = 1'b1;
        cpuReq = 1'b1;
        cpuWrite = write;
        cpuAddr = addr;
        cpuWriteData = data;
        @(posedge clk);
        #2;
        cpuReq = 1'b0;
    endtask

    task automatic finishAccess();
        @(negedge clk);
        while (!cpuDone) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        pending = 1'b0;
    endtask

    task automatic access(input string name, input bit write, input logic [31:0] addr,
                          input logic [31:0] data);
        startAccess(name, write, addr, data);
        finishAccess();
    endtask

    initial begin
        rstN = 1'b0;
        cpuReq = 1'b0;
        cpuWrite = 1'b0;
        cpuAddr = '0;
        cpuWriteData = '0;
        repeat (10) @(posedge clk);
        #2;
        rstN = 1'b1;

        access("read miss", 1'b0, makeAddr(23'h00012, 7'd1), '0);
        access("read hit", 1'b0, makeAddr(23'h00012, 7'd1), '0);
        access("read hit again", 1'b0, makeAddr(23'h00012, 7'd1), '0);

        // three tags in set 5.
        access("lru fill a", 1'b0, makeAddr(23'h00A01, 7'd5), '0);
        access("lru fill b", 1'b0, makeAddr(23'h00B02, 7'd5), '0);
        access("lru hit a", 1'b0, makeAddr(23'h00A01, 7'd5), '0);
        access("lru hit b", 1'b0, makeAddr(23'h00B02, 7'd5), '0);
        access("lru hit a last", 1'b0, makeAddr(23'h00A01, 7'd5), '0);
        access("lru evict b", 1'b0, makeAddr(23'h00C03, 7'd5), '0);
        access("evicted tag b", 1'b0, makeAddr(23'h00B02, 7'd5), '0);
        access("lru hit c", 1'b0, makeAddr(23'h00C03, 7'd5), '0);

        access("write hit", 1'b1, makeAddr(23'h00C03, 7'd5), 32'hDEAD_BEEF);
        access("read after write hit", 1'b0, makeAddr(23'h00C03, 7'd5), '0);
        access("write miss", 1'b1, makeAddr(23'h00D04, 7'd9), 32'h1234_5678);
        access("read after write miss", 1'b0, makeAddr(23'h00D04, 7'd9), '0);

        // a write request pulsed during the lookup is dropped.
        startAccess("requests while busy", 1'b0, makeAddr(23'h00E05, 7'd20), '0);
        cpuReq = 1'b1;
        cpuWrite = 1'b1;
        cpuAddr = makeAddr(23'h00F06, 7'd20);
        cpuWriteData = 32'hCAFE_F00D;
        @(posedge clk);
        #2;
        cpuReq = 1'b0;
        cpuWrite = 1'b0;
        finishAccess();
        repeat (8) @(posedge clk);
        access("dropped write target", 1'b0, makeAddr(23'h00F06, 7'd20), '0);

        $display("Done: no errors");
        $finish;
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("Watchdog expired before the tests finished.");
        abortRun();
    end

endmodule

// ==== sim.f ====
logic/cachePkg.sv
logic/wayPortIf.sv
logic/dualPortRam.sv
logic/cacheWay.sv
logic/lruTable.sv
logic/cacheController.sv
logic/cacheTop.sv
testbench/cacheTb.sv

// ==== Bender.yml ====
package:
  name: two_way_cache

sources:
  - logic/cachePkg.sv
  - logic/wayPortIf.sv
  - logic/dualPortRam.sv
  - logic/cacheWay.sv
  - logic/lruTable.sv
  - logic/cacheController.sv
  - logic/cacheTop.sv
  - target: simulation
    files:
      - testbench/cacheTb.sv
